/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Mdir obj_dir
TOP       = tb_regbank
FILELIST  = verilog.f
RUNFLAGS  = +verilator+error+limit+1000
LOG       = sim.log

.PHONY: sim clean

# the log is searched for the pass line, so a failing run returns an error
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* dv/regbank_assertions.sv */
module regbank_assertions (
    input logic               s_axi_aclk,
    input logic               s_axi_aresetn,
    input logic               awready,
    input logic               wready,
    input logic               arready,
    input logic               bvalid,
    input logic               bready,
    input logic               rvalid,
    input logic               rready,
    input regbank_pkg::data_t rdata
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    b_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
                             bvalid && !bready |=> bvalid)
    else
    begin
        $error("bvalid dropped while bready was low");
        fail_count++;
    end

    // read data must not move under a stalled rready
    r_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
                             rvalid && !rready |=> rvalid && $stable(rdata))
    else
    begin
        $error("rvalid or rdata changed while rready was low");
        fail_count++;
    end

    ready_after_reset: assert property (@(posedge s_axi_aclk)
                                        $rose(s_axi_aresetn) |-> awready && wready && arready)
    else
    begin
        $error("a ready was low in the first cycle after reset");
        fail_count++;
    end

endmodule

bind regbank_top regbank_assertions u_assert (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .awready       (s_axi_awready),
    .wready        (s_axi_wready),
    .arready       (s_axi_arready),
    .bvalid        (s_axi_bvalid),
    .bready        (s_axi_bready),
    .rvalid        (s_axi_rvalid),
    .rready        (s_axi_rready),
    .rdata         (s_axi_rdata)
);

/* dv/tb_regbank.sv */
module tb_regbank;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PAIRS   = 8;
    localparam int NUM_TXN     = 200;
    localparam int TIMEOUT_CYC = NUM_TXN * 24 + 50;

    localparam regbank_pkg::resp_t OKAY = 2'b00;  // AXI OKAY code

    logic s_axi_aclk;
    logic s_axi_aresetn;
    logic s_axi_awvalid;
    logic s_axi_awready;
    logic s_axi_wvalid;
    logic s_axi_wready;
    logic s_axi_bvalid;
    logic s_axi_bready;
    logic s_axi_arvalid;
    logic s_axi_arready;
    logic s_axi_rvalid;
    logic s_axi_rready;
    regbank_pkg::addr_t s_axi_awaddr;
    regbank_pkg::addr_t s_axi_araddr;
    regbank_pkg::data_t s_axi_wdata;
    regbank_pkg::data_t s_axi_rdata;
    regbank_pkg::strb_t s_axi_wstrb;
    regbank_pkg::resp_t s_axi_bresp;
    regbank_pkg::resp_t s_axi_rresp;
    regbank_pkg::data_t status_in [NUM_PAIRS];
    regbank_pkg::data_t ctrl_out  [NUM_PAIRS];

    regbank_pkg::data_t ctrl_model   [NUM_PAIRS];
    regbank_pkg::data_t status_model [NUM_PAIRS];  // last value driven on each status input

    int seed = 32'h639d;
    int cycles = 0;
    int tests = 0;
    int passes = 0;
    int errors = 0;

    regbank_top #(
        .NUM_PAIRS   (NUM_PAIRS),
        .SYNC_STAGES (2)
    ) dut (.*);

    always #50 s_axi_aclk = ~s_axi_aclk;

    always @(posedge s_axi_aclk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYC)
        begin
            $display("timeout after %0d cycles, a handshake never completed", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic int rand_range(int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic logic rand_bit();
        return rand_range(2) == 1;
    endfunction

    function automatic void model_write(int word, regbank_pkg::data_t data,
                                        regbank_pkg::strb_t strb);
        if (word < 2 * NUM_PAIRS && word % 2 == 1)  // odd words below the map end
        begin
            for (int b = 0; b < 4; b++)
                if (strb[b])
                    ctrl_model[word / 2][8*b +: 8] = data[8*b +: 8];
        end
    endfunction

    function automatic regbank_pkg::data_t model_read(int word);
        if (word >= 2 * NUM_PAIRS)
            return '0;
        else if (word % 2 == 1)
            return ctrl_model[word / 2];
        else
            return status_model[word / 2];
    endfunction

    task automatic check_data(input string name, input regbank_pkg::data_t exp,
                              input regbank_pkg::data_t act);
        if (act === exp)
            passes++;
        else
        begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_resp(input string name, input regbank_pkg::resp_t exp,
                              input regbank_pkg::resp_t act);
        if (act === exp)
            passes++;
        else
        begin
            errors++;
            $display("** Error %s resp: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic do_write(input string name, input int word, input regbank_pkg::data_t data,
                            input regbank_pkg::strb_t strb);
        int aw_dly;
        int w_dly;
        int cyc;
        bit aw_done;
        bit w_done;
        bit b_seen;
        bit b_done;
        aw_dly = rand_range(4);
        w_dly = 0;
        if (rand_bit())
        begin
            w_dly = aw_dly;
            aw_dly = 0;
        end
        aw_done = 1'b0;
        w_done = 1'b0;
        b_seen = 1'b0;
        b_done = 1'b0;
        cyc = 0;
        s_axi_awaddr = regbank_pkg::addr_t'(word << regbank_pkg::ADDR_LSB);
        s_axi_wdata = data;
        s_axi_wstrb = strb;
        while (!b_done)
        begin
            @(negedge s_axi_aclk);
            s_axi_awvalid = !aw_done && cyc >= aw_dly;
            s_axi_wvalid = !w_done && cyc >= w_dly;
            s_axi_bready = rand_bit();
            if (s_axi_awvalid && s_axi_awready)
                aw_done = 1'b1;  // beat goes on the coming edge
            if (s_axi_wvalid && s_axi_wready)
                w_done = 1'b1;
            if (s_axi_bvalid && !b_seen)
            begin
                b_seen = 1'b1;
                model_write(word, data, strb);
                for (int p = 0; p < NUM_PAIRS; p++)
                    check_data($sformatf("%s ctrl%0d", name, p), ctrl_model[p], ctrl_out[p]);
            end
            if (s_axi_bvalid && s_axi_bready)
            begin
                b_done = 1'b1;
                check_resp(name, OKAY, s_axi_bresp);
            end
            cyc++;
        end
    endtask

    task automatic do_read(input string name, input int word);
        bit ar_done;
        bit r_done;
        ar_done = 1'b0;
        r_done = 1'b0;
        s_axi_araddr = regbank_pkg::addr_t'(word << regbank_pkg::ADDR_LSB);
        while (!r_done)
        begin
            @(negedge s_axi_aclk);
            s_axi_arvalid = !ar_done;
            s_axi_rready = rand_bit();
            if (s_axi_arvalid && s_axi_arready)
                ar_done = 1'b1;
            if (s_axi_rvalid && s_axi_rready)
            begin
                r_done = 1'b1;
                check_data(name, model_read(word), s_axi_rdata);
                check_resp(name, OKAY, s_axi_rresp);
            end
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        @(negedge s_axi_aclk);
        if (s_axi_bvalid || s_axi_rvalid)
        begin
            errors++;
            $display("%s: response still valid after its handshake", name);
        end
        tests++;
        $display("%-28s %s", name, (errors == err_before) ? "ok" : "FAIL");
    endtask

    initial
    begin
        int word;
        int p;
        int err_before;
        string name;
        regbank_pkg::data_t data;
        regbank_pkg::strb_t strb;
        s_axi_aclk = 1'b0;
        s_axi_aresetn = 1'b0;
        s_axi_awvalid = 1'b0;
        s_axi_wvalid = 1'b0;
        s_axi_arvalid = 1'b0;
        s_axi_bready = 1'b0;
        s_axi_rready = 1'b0;
        s_axi_awaddr = '0;
        s_axi_araddr = '0;
        s_axi_wdata = '0;
        s_axi_wstrb = '0;
        for (int i = 0; i < NUM_PAIRS; i++)
        begin
            status_in[i] = '0;
            ctrl_model[i] = '0;
            status_model[i] = '0;
        end
        repeat (2) @(negedge s_axi_aclk);
        s_axi_aresetn = 1'b1;

        err_before = errors;
        for (int i = 0; i < NUM_PAIRS; i++)
            check_data($sformatf("reset ctrl%0d", i), '0, ctrl_out[i]);
        end_test("reset_ctrl", err_before);
        for (int w = 0; w < 32; w++)
        begin
            err_before = errors;
            name = $sformatf("reset_rd_w%0d", w);
            do_read(name, w);
            end_test(name, err_before);
        end

        for (int n = 0; n < NUM_TXN; n++)
        begin
            if (rand_range(4) == 0)
            begin
                p = rand_range(NUM_PAIRS);
                status_in[p] = $random(seed);
                status_model[p] = status_in[p];
                repeat (4) @(negedge s_axi_aclk);  // sync chain plus read register
            end
            word = rand_range(32);
            err_before = errors;
            if (rand_bit())
            begin
                data = $random(seed);
                strb = rand_bit() ? 4'hf : regbank_pkg::strb_t'(rand_range(16));
                name = $sformatf("t%0d_wr_w%0d_s%h", n, word, strb);
                do_write(name, word, data, strb);
            end
            else
            begin
                name = $sformatf("t%0d_rd_w%0d", n, word);
                do_read(name, word);
            end
            end_test(name, err_before);
        end

        if (dut.u_assert.fail_count != 0)
            $display("%0d bus protocol assertions failed", dut.u_assert.fail_count);
        errors += dut.u_assert.fail_count;
        $display("%0d tests, %0d checks passed, %0d errors", tests, passes, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* src/axi_read_result.sv */
module axi_read_result (
    input  logic                  s_axi_aclk,
    input  logic                  s_axi_aresetn,
    input  regbank_pkg::addr_t    araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic                  rvalid,
    input  logic                  rready,
    output regbank_pkg::data_t    rdata,
    output regbank_pkg::reg_idx_u rd_idx,
    input  regbank_pkg::data_t    rd_word
);

    regbank_pkg::addr_t ar_buf;
    regbank_pkg::addr_t raddr;

    logic rd_pending;
    logic r_stall;

    assign rd_pending = arvalid || !arready;  // new address or one held
    assign r_stall    = rvalid && !rready;

    always_ff @(posedge s_axi_aclk)
    begin
        if (!s_axi_aresetn)
            rvalid <= 1'b0;
        else if (r_stall)
            rvalid <= 1'b1;
        else
            rvalid <= rd_pending;
    end

    always_ff @(posedge s_axi_aclk)
    begin
        if (!s_axi_aresetn)
            arready <= 1'b1;
        else if (r_stall)
            arready <= !rd_pending;
        else
            arready <= 1'b1;
    end

    always_ff @(posedge s_axi_aclk)
    begin
        if (arready)
            ar_buf <= araddr;
    end

    assign raddr  = arready ? araddr : ar_buf;
    assign rd_idx = raddr[regbank_pkg::ADDR_WIDTH-1:regbank_pkg::ADDR_LSB];

    // rdata only moves when the slot is free
    always_ff @(posedge s_axi_aclk)
    begin
        if (!s_axi_aresetn)
            rdata <= '0;
        else if (!r_stall && rd_pending)
            rdata <= rd_word;
    end

endmodule

/* src/axi_write_decode.sv */
module axi_write_decode (
    input  logic                  s_axi_aclk,
    input  logic                  s_axi_aresetn,
    input  regbank_pkg::addr_t    awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  regbank_pkg::data_t    wdata,
    input  regbank_pkg::strb_t    wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic                  bvalid,
    input  logic                  bready,
    output logic                  wr_en,
    output regbank_pkg::reg_idx_u wr_idx,
    output regbank_pkg::data_t    wr_data,
    output regbank_pkg::strb_t    wr_strb
);

    regbank_pkg::addr_t aw_buf;
    regbank_pkg::data_t w_buf_data;
    regbank_pkg::strb_t w_buf_strb;
    regbank_pkg::addr_t waddr;

    logic aw_pending;
    logic w_pending;
    logic b_stall;

    // a ready low means that channel's buffer is full
    assign aw_pending = awvalid || !awready;
    assign w_pending  = wvalid || !wready;
    assign b_stall    = bvalid && !bready;

    assign wr_en = aw_pending && w_pending && !b_stall;

    always_ff @(posedge s_axi_aclk)
    begin
        if (!s_axi_aresetn)
            awready <= 1'b1;
        else if (b_stall)
            awready <= !aw_pending;  // hold anything that is waiting
        else if (w_pending)
            awready <= 1'b1;
        else
            awready <= awready && !awvalid;
    end

    always_ff @(posedge s_axi_aclk)
    begin
        if (!s_axi_aresetn)
            wready <= 1'b1;
        else if (b_stall)
            wready <= !w_pending;
        else if (aw_pending)
            wready <= 1'b1;
        else
            wready <= wready && !wvalid;
    end

    // skid buffers follow the bus while empty
    always_ff @(posedge s_axi_aclk)
    begin
        if (awready)
            aw_buf <= awaddr;
    end

    always_ff @(posedge s_axi_aclk)
    begin
        if (wready)
        begin
            w_buf_data <= wdata;
            w_buf_strb <= wstrb;
        end
    end

    assign waddr   = awready ? awaddr : aw_buf;
    assign wr_idx  = waddr[regbank_pkg::ADDR_WIDTH-1:regbank_pkg::ADDR_LSB];
    assign wr_data = wready ? wdata : w_buf_data;
    assign wr_strb = wready ? wstrb : w_buf_strb;

    always_ff @(posedge s_axi_aclk)
    begin
        if (!s_axi_aresetn)
            bvalid <= 1'b0;
        else if (wr_en)
            bvalid <= 1'b1;
        else if (bready)
            bvalid <= 1'b0;
    end

endmodule

/* src/reg_file.sv */
module reg_file #(
    parameter int NUM_PAIRS   = 8,
    parameter int SYNC_STAGES = 2
) (
    input  logic                  s_axi_aclk,
    input  logic                  s_axi_aresetn,
    input  logic                  wr_en,
    input  regbank_pkg::reg_idx_u wr_idx,
    input  regbank_pkg::data_t    wr_data,
    input  regbank_pkg::strb_t    wr_strb,
    input  regbank_pkg::reg_idx_u rd_idx,
    output regbank_pkg::data_t    rd_word,
    input  regbank_pkg::data_t    status_in [NUM_PAIRS],
    output regbank_pkg::data_t    ctrl_out  [NUM_PAIRS]
);

    regbank_pkg::data_t ctrl_q   [NUM_PAIRS];
    regbank_pkg::data_t sync_out [NUM_PAIRS];
    regbank_pkg::data_t status_r [NUM_PAIRS];

    logic wr_ctrl;
    logic rd_in_range;

    status_sync #(
        .NUM_PAIRS   (NUM_PAIRS),
        .SYNC_STAGES (SYNC_STAGES)
    ) u_status_sync (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .status_in     (status_in),
        .status_q      (sync_out)
    );

    // status words are read only, unmapped pairs drop the write
    assign wr_ctrl = wr_en && (wr_idx.fld.kind == regbank_pkg::KIND_CTRL)
                     && (int'(wr_idx.fld.pair) < NUM_PAIRS);

    always_ff @(posedge s_axi_aclk)
    begin
        if (!s_axi_aresetn)
        begin
            for (int p = 0; p < NUM_PAIRS; p++)
            begin
                ctrl_q[p]   <= '0;
                status_r[p] <= '0;
            end
        end
        else
        begin
            for (int p = 0; p < NUM_PAIRS; p++)
            begin
                status_r[p] <= sync_out[p];
                if (wr_ctrl && int'(wr_idx.fld.pair) == p)
                begin
                    for (int b = 0; b < regbank_pkg::STRB_WIDTH; b++)
                    begin
                        if (wr_strb[b])
                            ctrl_q[p][8*b +: 8] <= wr_data[8*b +: 8];
                    end
                end
            end
        end
    end

    assign ctrl_out = ctrl_q;

    // word number checks the map, pair and kind pick the source
    assign rd_in_range = int'(rd_idx.raw) < 2 * NUM_PAIRS;

    always_comb
    begin
        rd_word = '0;
        if (rd_in_range)
        begin
            for (int p = 0; p < NUM_PAIRS; p++)
            begin
                if (int'(rd_idx.fld.pair) == p)
                begin
                    if (rd_idx.fld.kind == regbank_pkg::KIND_CTRL)
                        rd_word = ctrl_q[p];
                    else
                        rd_word = status_r[p];
                end
            end
        end
    end

endmodule

/* src/regbank_pkg.sv */
package regbank_pkg;

    localparam int MAX_PAIRS  = 16;
    localparam int REG_IDX_W  = $clog2(MAX_PAIRS) + 1;  // pair number plus kind bit
    localparam int ADDR_LSB   = 2;
    localparam int ADDR_WIDTH = REG_IDX_W + ADDR_LSB;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [STRB_WIDTH-1:0] strb_t;
    typedef logic [1:0]            resp_t;

    localparam resp_t RESP_OKAY = 2'b00;

    // even word is status, odd word is control
    typedef enum logic {
        KIND_STATUS = 1'b0,
        KIND_CTRL   = 1'b1
    } reg_kind_e;

    typedef struct packed {
        logic [REG_IDX_W-2:0] pair;
        reg_kind_e            kind;
    } reg_fields_t;

    // same word index, seen as a word number or as pair and kind
    typedef union packed {
        logic [REG_IDX_W-1:0] raw;
        reg_fields_t          fld;
    } reg_idx_u;

endpackage

/* src/regbank_top.sv */
module regbank_top #(
    parameter int NUM_PAIRS   = 8,
    parameter int SYNC_STAGES = 2
) (
    input  logic               s_axi_aclk,
    input  logic               s_axi_aresetn,
    input  regbank_pkg::addr_t s_axi_awaddr,
    input  logic               s_axi_awvalid,
    output logic               s_axi_awready,
    input  regbank_pkg::data_t s_axi_wdata,
    input  regbank_pkg::strb_t s_axi_wstrb,
    input  logic               s_axi_wvalid,
    output logic               s_axi_wready,
    output regbank_pkg::resp_t s_axi_bresp,
    output logic               s_axi_bvalid,
    input  logic               s_axi_bready,
    input  regbank_pkg::addr_t s_axi_araddr,
    input  logic               s_axi_arvalid,
    output logic               s_axi_arready,
    output regbank_pkg::data_t s_axi_rdata,
    output regbank_pkg::resp_t s_axi_rresp,
    output logic               s_axi_rvalid,
    input  logic               s_axi_rready,
    input  regbank_pkg::data_t status_in [NUM_PAIRS],
    output regbank_pkg::data_t ctrl_out  [NUM_PAIRS]
);

    logic                  wr_en;
    regbank_pkg::reg_idx_u wr_idx;
    regbank_pkg::data_t    wr_data;
    regbank_pkg::strb_t    wr_strb;
    regbank_pkg::reg_idx_u rd_idx;
    regbank_pkg::data_t    rd_word;

    // no error cases, unmapped words just read zero
    assign s_axi_bresp = regbank_pkg::RESP_OKAY;
    assign s_axi_rresp = regbank_pkg::RESP_OKAY;

    axi_write_decode u_write (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .awaddr        (s_axi_awaddr),
        .awvalid       (s_axi_awvalid),
        .awready       (s_axi_awready),
        .wdata         (s_axi_wdata),
        .wstrb         (s_axi_wstrb),
        .wvalid        (s_axi_wvalid),
        .wready        (s_axi_wready),
        .bvalid        (s_axi_bvalid),
        .bready        (s_axi_bready),
        .wr_en         (wr_en),
        .wr_idx        (wr_idx),
        .wr_data       (wr_data),
        .wr_strb       (wr_strb)
    );

    reg_file #(
        .NUM_PAIRS   (NUM_PAIRS),
        .SYNC_STAGES (SYNC_STAGES)
    ) u_reg_file (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .wr_en         (wr_en),
        .wr_idx        (wr_idx),
        .wr_data       (wr_data),
        .wr_strb       (wr_strb),
        .rd_idx        (rd_idx),
        .rd_word       (rd_word),
        .status_in     (status_in),
        .ctrl_out      (ctrl_out)
    );

    axi_read_result u_read (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .araddr        (s_axi_araddr),
        .arvalid       (s_axi_arvalid),
        .arready       (s_axi_arready),
        .rvalid        (s_axi_rvalid),
        .rready        (s_axi_rready),
        .rdata         (s_axi_rdata),
        .rd_idx        (rd_idx),
        .rd_word       (rd_word)
    );

endmodule

/* src/status_sync.sv */
module status_sync #(
    parameter int NUM_PAIRS   = 8,
    parameter int SYNC_STAGES = 2
) (
    input  logic               s_axi_aclk,
    input  logic               s_axi_aresetn,
    input  regbank_pkg::data_t status_in [NUM_PAIRS],
    output regbank_pkg::data_t status_q  [NUM_PAIRS]
);

    (* ASYNC_REG = "TRUE" *) regbank_pkg::data_t sync_q [NUM_PAIRS][SYNC_STAGES];

    always_ff @(posedge s_axi_aclk)
    begin
        if (!s_axi_aresetn)
        begin
            for (int p = 0; p < NUM_PAIRS; p++)
                for (int s = 0; s < SYNC_STAGES; s++)
                    sync_q[p][s] <= '0;
        end
        else
        begin
            for (int p = 0; p < NUM_PAIRS; p++)
            begin
                sync_q[p][0] <= status_in[p];  // first stage may go metastable
                for (int s = 1; s < SYNC_STAGES; s++)
                    sync_q[p][s] <= sync_q[p][s-1];
            end
        end
    end

    always_comb
    begin
        for (int p = 0; p < NUM_PAIRS; p++)
            status_q[p] = sync_q[p][SYNC_STAGES-1];
    end

endmodule

/* verilog.f */
src/regbank_pkg.sv
src/axi_write_decode.sv
src/status_sync.sv
src/reg_file.sv
src/axi_read_result.sv
src/regbank_top.sv
dv/regbank_assertions.sv
dv/tb_regbank.sv
